/* rtl/bus_cfg_pkg.sv */
package bus_cfg_pkg;

  //////////////////////////////
  // bus sizing
  //////////////////////////////

  // drivers sharing the serial line
  localparam int num_drivers = 4;

  // bits per packet, sent msb first
  localparam int pkt_width = 16;

  // destination field sits in the top bits of a packet
  localparam int addr_width = 8;

  //////////////////////////////
  // addressing
  //////////////////////////////

  // reaches every driver except the sender
  localparam logic [addr_width-1:0] broadcast_addr = '1;

endpackage

/* rtl/bus_types_pkg.sv */
package bus_types_pkg;

  import bus_cfg_pkg::*;

  //////////////////////////////
  // payload types
  //////////////////////////////

  // one packet as it sits in the source and sink queues
  typedef logic [pkt_width-1:0] pkt_t;

  // destination field, upper addr_width bits of pkt_t
  typedef logic [addr_width-1:0] addr_t;

  //////////////////////////////
  // control types
  //////////////////////////////

  // index of one driver on the bus
  typedef logic [$clog2(num_drivers)-1:0] drv_id_t;

  // serial bit count, wide enough to hold pkt_width itself
  typedef logic [$clog2(pkt_width):0] bit_cnt_t;

  // transmit side of one driver
  typedef enum logic [1:0] {
    idle,
    wait_grant,
    send
  } tx_state_t;

endpackage

/* rtl/bus_access_if.sv */
interface bus_access_if;

  import bus_cfg_pkg::*;

  // each transmitter drives only its own bit of these nets
  wire [num_drivers-1:0] rqst;
  wire [num_drivers-1:0] tx_data;
  wire [num_drivers-1:0] tx_frame;

  // one-hot, registered in the arbiter
  logic [num_drivers-1:0] grnt;

  //////////////////////////////
  // modports
  //////////////////////////////

  modport tx (
    output rqst,
    output tx_data,
    output tx_frame,
    input  grnt
  );

  modport arb (
    input  rqst,
    input  tx_data,
    input  tx_frame,
    output grnt
  );

endinterface

/* rtl/bus_transmitter.sv */
module bus_transmitter #(
  parameter bus_types_pkg::drv_id_t own_id = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                pndng,
  input  bus_types_pkg::pkt_t d_pop,
  output logic                pop,
  bus_access_if.tx            acc
);

  import bus_cfg_pkg::*;
  import bus_types_pkg::*;

  tx_state_t state;
  pkt_t      shreg;
  bit_cnt_t  bit_cnt;
  logic      granted;
  logic      last_bit;

  //////////////////////////////
  // source queue side
  //////////////////////////////

  // show-ahead queue, so the head is taken in the same cycle as pop
  assign pop = (state == idle) && pndng;

  assign granted  = acc.grnt[own_id];
  assign last_bit = (state == send) && (bit_cnt == bit_cnt_t'(pkt_width - 1));

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (pndng) begin
            state <= wait_grant;
          end
        end
        wait_grant: begin
          // first cycle with our grant starts the frame
          if (granted) begin
            state <= send;
          end
        end
        send: begin
          if (last_bit) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // counts bits already on the line, cleared outside of send
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (state != send) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // serializer
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (pop) begin
      shreg <= d_pop;
    end else if (state == send) begin
      shreg <= {shreg[pkt_width-2:0], 1'b0};
    end
  end

  // request stays up from capture until the last bit is out
  assign acc.rqst[own_id]     = (state != idle);
  assign acc.tx_frame[own_id] = (state == send);
  assign acc.tx_data[own_id]  = (state == send) && shreg[pkt_width-1];

endmodule

/* rtl/bus_arbiter.sv */
module bus_arbiter (
  input  logic      clk,
  input  logic      rst,
  bus_access_if.arb acc,
  output logic      bus_data,
  output logic      bus_frame
);

  import bus_cfg_pkg::*;
  import bus_types_pkg::*;

  drv_id_t ptr;
  drv_id_t ptr_next;
  logic    any_rqst;
  logic    grant_held;

  //////////////////////////////
  // round-robin pointer
  //////////////////////////////

  assign ptr_next   = (ptr == drv_id_t'(num_drivers - 1)) ? '0 : ptr + 1'b1;
  assign any_rqst   = |acc.rqst;
  assign grant_held = |acc.grnt;

  // the grant, when held, always belongs to the driver at ptr
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ptr      <= '0;
      acc.grnt <= '0;
    end else if (grant_held) begin
      // owner dropped its request, release and move on
      if (!acc.rqst[ptr]) begin
        acc.grnt <= '0;
        ptr      <= ptr_next;
      end
    end else if (any_rqst) begin
      if (acc.rqst[ptr]) begin
        acc.grnt <= num_drivers'(1) << ptr;
      end else begin
        ptr <= ptr_next;
      end
    end
  end

  //////////////////////////////
  // shared line
  //////////////////////////////

  // and-or select of the granted driver, idle low with no grant
  always_comb begin
    bus_data  = |(acc.grnt & acc.tx_data);
    bus_frame = |(acc.grnt & acc.tx_frame);
  end

endmodule

/* rtl/bus_receiver.sv */
module bus_receiver #(
  parameter bus_types_pkg::drv_id_t own_id = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                bus_data,
  input  logic                bus_frame,
  input  logic                own_grant,
  output bus_types_pkg::pkt_t d_push,
  output logic                push
);

  import bus_cfg_pkg::*;
  import bus_types_pkg::*;

  pkt_t     shreg;
  pkt_t     shift_next;
  bit_cnt_t bit_cnt;
  addr_t    dest;
  logic     shift_en;
  logic     last_bit;
  logic     addr_hit;

  //////////////////////////////
  // deserializer
  //////////////////////////////

  // a driver never listens to its own frame
  assign shift_en   = bus_frame && !own_grant;
  assign shift_next = {shreg[pkt_width-2:0], bus_data};
  assign last_bit   = shift_en && (bit_cnt == bit_cnt_t'(pkt_width - 1));

  always_ff @(posedge clk) begin
    if (shift_en) begin
      shreg <= shift_next;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (!shift_en || last_bit) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // address match and push
  //////////////////////////////

  // checked on the packet as completed by the current bit
  assign dest     = shift_next[pkt_width-1 -: addr_width];
  assign addr_hit = (dest == addr_t'(own_id)) || (dest == broadcast_addr);

  // push lands one cycle after the last bit, d_push holds until the next one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      push   <= 1'b0;
      d_push <= '0;
    end else begin
      push <= last_bit && addr_hit;
      if (last_bit && addr_hit) begin
        d_push <= shift_next;
      end
    end
  end

endmodule

/* rtl/serial_bus_top.sv */
module serial_bus_top (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                [bus_cfg_pkg::num_drivers-1:0] pndng,
  output logic                [bus_cfg_pkg::num_drivers-1:0] pop,
  input  bus_types_pkg::pkt_t [bus_cfg_pkg::num_drivers-1:0] d_pop,
  output logic                [bus_cfg_pkg::num_drivers-1:0] push,
  output bus_types_pkg::pkt_t [bus_cfg_pkg::num_drivers-1:0] d_push
);

  import bus_cfg_pkg::*;
  import bus_types_pkg::*;

  logic bus_data;
  logic bus_frame;

  // request, grant and per-driver transmit lines
  bus_access_if acc ();

  //////////////////////////////
  // drivers
  //////////////////////////////

  for (genvar i = 0; i < num_drivers; i++) begin : g_drv

    bus_transmitter #(
      .own_id(drv_id_t'(i))
    ) u_tx (
      .clk  (clk),
      .rst  (rst),
      .pndng(pndng[i]),
      .d_pop(d_pop[i]),
      .pop  (pop[i]),
      .acc  (acc.tx)
    );

    // own grant keeps the sender deaf to its own frame
    bus_receiver #(
      .own_id(drv_id_t'(i))
    ) u_rx (
      .clk      (clk),
      .rst      (rst),
      .bus_data (bus_data),
      .bus_frame(bus_frame),
      .own_grant(acc.grnt[i]),
      .d_push   (d_push[i]),
      .push     (push[i])
    );

  end

  //////////////////////////////
  // arbiter and shared line
  //////////////////////////////

  bus_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .acc      (acc.arb),
    .bus_data (bus_data),
    .bus_frame(bus_frame)
  );

endmodule

/* sim/bus_checker.sv */
module bus_checker (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                [bus_cfg_pkg::num_drivers-1:0] pndng,
  input  logic                [bus_cfg_pkg::num_drivers-1:0] pop,
  input  bus_types_pkg::pkt_t [bus_cfg_pkg::num_drivers-1:0] d_pop,
  input  logic                [bus_cfg_pkg::num_drivers-1:0] push,
  input  bus_types_pkg::pkt_t [bus_cfg_pkg::num_drivers-1:0] d_push,
  output int                                                 error_count,
  output int                                                 pending
);

  import bus_cfg_pkg::*;
  import bus_types_pkg::*;

  localparam int exp_depth = 256;

  // one circular expected queue per receiver
  pkt_t exp_mem [num_drivers][exp_depth];
  int   exp_head [num_drivers];
  int   exp_cnt [num_drivers];
  int   test_count;
  int   failed_tests;
  int   errors_at_start;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // unicast reaches the addressed driver, all ones reaches everyone, never the sender
  function automatic logic [num_drivers-1:0] expected_receivers(input int source,
                                                                input pkt_t packet);
    int                     dest;
    logic [num_drivers-1:0] hits;
    dest = int'(packet[pkt_width-1 -: addr_width]);
    hits = '0;
    if (dest == (1 << addr_width) - 1) begin
      hits = '1;
    end else if (dest < num_drivers) begin
      hits[dest] = 1'b1;
    end
    hits[source] = 1'b0;
    return hits;
  endfunction

  initial begin
    error_count     = 0;
    pending         = 0;
    test_count      = 0;
    failed_tests    = 0;
    errors_at_start = 0;
    for (int r = 0; r < num_drivers; r++) begin
      exp_head[r] = 0;
      exp_cnt[r]  = 0;
    end
  end

  //////////////////////////////
  // compare
  //////////////////////////////

  always @(posedge clk) begin : compare_proc
    logic [num_drivers-1:0] hits;
    pkt_t                   expected;
    int                     slot;
    if (!rst) begin
      // deliveries first, a pop in the same cycle is always a newer packet
      for (int r = 0; r < num_drivers; r++) begin
        if (push[r] && exp_cnt[r] == 0) begin
          $display("error at %0t: driver %0d pushed %h with nothing expected there",
                   $time, r, d_push[r]);
          error_count++;
        end else if (push[r]) begin
          expected = exp_mem[r][exp_head[r]];
          if (d_push[r] !== expected) begin
            $display("FAIL %0t d_push[%0d] got %h expected %h", $time, r, d_push[r], expected);
            error_count++;
          end
          exp_head[r] = (exp_head[r] + 1) % exp_depth;
          exp_cnt[r]--;
          pending--;
        end
      end
      for (int s = 0; s < num_drivers; s++) begin
        if (pop[s]) begin
          if (!pndng[s]) begin
            $display("error at %0t: driver %0d popped from an empty source queue", $time, s);
            error_count++;
          end
          hits = expected_receivers(s, d_pop[s]);
          for (int r = 0; r < num_drivers; r++) begin
            if (hits[r]) begin
              slot = (exp_head[r] + exp_cnt[r]) % exp_depth;
              exp_mem[r][slot] = d_pop[s];
              exp_cnt[r]++;
              pending++;
            end
          end
        end
      end
    end
  end

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic finish_test(input string name);
    int test_errors;
    for (int r = 0; r < num_drivers; r++) begin
      if (exp_cnt[r] != 0) begin
        $display("error: driver %0d still waits for %0d packets", r, exp_cnt[r]);
        error_count++;
      end
    end
    test_errors     = error_count - errors_at_start;
    errors_at_start = error_count;
    test_count++;
    if (test_errors == 0) begin
      $display("test %s: passed", name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
  endtask

  task automatic report_totals();
    $display("tests run %0d, tests failed %0d, errors %0d",
             test_count, failed_tests, error_count);
  endtask

endmodule

/* sim/serial_bus_tb.sv */
module serial_bus_tb;

  import bus_cfg_pkg::*;
  import bus_types_pkg::*;

  localparam int src_depth     = 256;
  localparam int burst_per_drv = 5;
  localparam int random_pkts   = 200;
  localparam int total_pkts    = 3 + num_drivers * burst_per_drv + random_pkts;
  // bus time for one packet including arbitration and margin
  localparam int slot_cycles   = num_drivers + pkt_width + 8;
  localparam int max_cycles    = total_pkts * slot_cycles + 200;
  localparam int drain_cycles  = num_drivers * slot_cycles;
  localparam logic [31:0] seed = 32'hbfd9;

  logic                   clk;
  logic                   rst;
  logic [num_drivers-1:0] pndng;
  logic [num_drivers-1:0] pop;
  logic [num_drivers-1:0] push;
  pkt_t [num_drivers-1:0] d_pop;
  pkt_t [num_drivers-1:0] d_push;
  int                     error_count;
  int                     pending;
  int                     cycle_cnt;

  // one circular source queue per driver
  pkt_t src_mem [num_drivers][src_depth];
  int   src_head [num_drivers];
  int   src_cnt [num_drivers];

  serial_bus_top u_serial_bus_top (
    .clk   (clk),
    .rst   (rst),
    .pndng (pndng),
    .pop   (pop),
    .d_pop (d_pop),
    .push  (push),
    .d_push(d_push)
  );

  bus_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .pndng      (pndng),
    .pop        (pop),
    .d_pop      (d_pop),
    .push       (push),
    .d_push     (d_push),
    .error_count(error_count),
    .pending    (pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // show-ahead source side
  //////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      pndng <= '0;
      d_pop <= '0;
    end else begin
      for (int i = 0; i < num_drivers; i++) begin
        if (pop[i] && src_cnt[i] > 0) begin
          src_head[i] = (src_head[i] + 1) % src_depth;
          src_cnt[i]--;
        end
        pndng[i] <= (src_cnt[i] != 0);
        d_pop[i] <= src_mem[i][src_head[i]];
      end
    end
  end

  task automatic add_packet(input int src, input addr_t dest,
                            input logic [pkt_width-addr_width-1:0] payload);
    int slot;
    while (src_cnt[src] == src_depth) begin
      @(negedge clk);
    end
    slot = (src_head[src] + src_cnt[src]) % src_depth;
    src_mem[src][slot] = {dest, payload};
    src_cnt[src]++;
  endtask

  // waits until the sources are empty and nothing is in flight
  task automatic wait_drained();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = (pending != 0) || (pndng != '0);
      for (int i = 0; i < num_drivers; i++) begin
        if (src_cnt[i] != 0) begin
          busy = 1'b1;
        end
      end
    end
    // quiet window to catch late or stray pushes
    repeat (drain_cycles) @(negedge clk);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    int    src;
    int    pick;
    int    gap;
    addr_t dest;
    rst   = 1'b1;
    pndng = '0;
    d_pop = '0;
    for (int i = 0; i < num_drivers; i++) begin
      src_head[i] = 0;
      src_cnt[i]  = 0;
    end
    void'($urandom(seed));
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(negedge clk);

    add_packet(0, 8'd2, 8'h5a);
    wait_drained();
    u_checker.finish_test("unicast from 0 to 2");

    add_packet(1, broadcast_addr, 8'hc3);
    wait_drained();
    u_checker.finish_test("broadcast from 1");

    add_packet(3, 8'h40, 8'h11);
    wait_drained();
    u_checker.finish_test("unused address");

    // every driver loaded at once with a broadcast closing each burst
    for (int i = 0; i < num_drivers; i++) begin
      for (int k = 0; k < burst_per_drv; k++) begin
        dest = (k == burst_per_drv - 1) ? broadcast_addr : addr_t'((i + k) % num_drivers);
        add_packet(i, dest, 8'(i * 16 + k));
      end
    end
    wait_drained();
    u_checker.finish_test("all drivers busy");

    for (int n = 0; n < random_pkts; n++) begin
      gap = $urandom_range(0, 7);
      repeat (gap) @(negedge clk);
      src  = $urandom_range(0, num_drivers - 1);
      pick = $urandom_range(0, 5);
      if (pick <= 3) begin
        dest = addr_t'($urandom_range(0, num_drivers - 1));
      end else if (pick == 4) begin
        dest = broadcast_addr;
      end else begin
        dest = addr_t'($urandom_range(num_drivers, 254));
      end
      add_packet(src, dest, 8'($urandom));
    end
    wait_drained();
    u_checker.finish_test("random traffic");

    u_checker.report_totals();
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run stopped after %0d cycles with traffic still pending", max_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* files.f */
rtl/bus_cfg_pkg.sv
rtl/bus_types_pkg.sv
rtl/bus_access_if.sv
rtl/bus_transmitter.sv
rtl/bus_arbiter.sv
rtl/bus_receiver.sv
rtl/serial_bus_top.sv
sim/bus_checker.sv
sim/serial_bus_tb.sv
